//--- common/readEnginePkg.sv
// Shared definitions for the read engine: sizes, latencies, field types
// and the request/response structs passed between its stages

package readEnginePkg;

    // Number of words in the data memory
    localparam int memDepth = 64;

    // Number of reorder scoreboard slots
    localparam int sbEntries = 16;

    // Request to response latency of the even (fast) bank
    localparam int fastLatency = 1;

    // Request to response latency of the odd (slow) bank
    localparam int slowLatency = 4;

    // Length of the service delay line, which also bounds the worst latency
    localparam int delayStages = 6;

    // One data word
    typedef logic [31:0] tData;

    // Word address into the data memory, wraps naturally at memDepth
    typedef logic [$clog2(memDepth)-1:0] tAddr;

    // Scoreboard slot index, also used as the read tag
    typedef logic [$clog2(sbEntries)-1:0] tTag;

    // Word count of a command; one extra bit so a full 16-word burst fits
    typedef logic [$clog2(sbEntries):0] tCount;

    // Tagged read request from the splitter to the memory service
    typedef struct packed
    {
        tTag  tag;
        tAddr addr;
    } readReqT;

    // Tagged read response from the memory service to the scoreboard
    typedef struct packed
    {
        tTag  tag;
        tData data;
    } readRspT;

    // Drain stage states
    typedef enum logic
    {
        idle,
        draining
    } drainStateT;

endpackage

//--- readService/readService.sv
// Two-bank memory service: even addresses answer fast, odd addresses slow,
// so tagged responses leave a shared delay line out of request order

`timescale 1ns/100ps

module readService
(
    input  logic                   clk,
    input  logic                   resetb,
    input  logic                   memWrEn,
    input  readEnginePkg::tAddr    memWrAddr,
    input  readEnginePkg::tData    memWrData,
    input  logic                   reqValid,
    input  readEnginePkg::readReqT reqData,
    output logic                   rspValid,
    output readEnginePkg::readRspT rspData
);

    localparam int stageBits = $clog2(readEnginePkg::delayStages);

    // Backing store shared by both banks
    readEnginePkg::tData mem [readEnginePkg::memDepth];

    // Delay line, index 0 is presented on the outputs
    // An entry written at index k leaves k+1 cycles after its request
    logic [readEnginePkg::delayStages-1:0] lineValid;
    readEnginePkg::readRspT                lineRsp [readEnginePkg::delayStages];

    // Occupancy of each stage after this cycle's shift
    logic [readEnginePkg::delayStages-1:0] nextBusy;

    // Word read for the incoming request
    readEnginePkg::tData memRd;

    // Stage chosen for the incoming request
    logic [stageBits-1:0] targetStage;
    logic [stageBits-1:0] placeStage;
    logic                 placeFound;

    assign memRd = mem[reqData.addr];

    // Everything moves one step toward the output and the top stage empties
    assign nextBusy = {1'b0, lineValid[readEnginePkg::delayStages-1:1]};

    always_comb
    begin
        // Bank is selected by the lowest address bit
        if (reqData.addr[0])
        begin
            targetStage = stageBits'(readEnginePkg::slowLatency - 1);
        end
        else
        begin
            targetStage = stageBits'(readEnginePkg::fastLatency - 1);
        end

        // Take the bank's own stage, or the first free one later than it
        placeStage = targetStage;
        placeFound = 1'b0;
        for (int i = 0; i < readEnginePkg::delayStages; i++)
        begin
            if (!placeFound && (i >= targetStage) && !nextBusy[i])
            begin
                placeStage = stageBits'(i);
                placeFound = 1'b1;
            end
        end
    end

    // Valid bits of the delay line
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            lineValid <= '0;
        end
        else
        begin
            lineValid <= nextBusy;
            if (reqValid && placeFound)
            begin
                lineValid[placeStage] <= 1'b1;
            end
        end
    end

    // Payload of the delay line and the memory array
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < readEnginePkg::delayStages - 1; i++)
        begin
            lineRsp[i] <= lineRsp[i + 1];
        end

        if (reqValid)
        begin
            lineRsp[placeStage].tag  <= reqData.tag;
            lineRsp[placeStage].data <= memRd;
        end

        if (memWrEn)
        begin
            mem[memWrAddr] <= memWrData;
        end
    end

    // At most one response per cycle, straight from the head stage
    assign rspValid = lineValid[0];
    assign rspData  = lineRsp[0];

    // A request is never dropped for lack of a delay stage
    assert property (@(posedge clk) disable iff (!resetb)
        reqValid |-> placeFound)
    else $error("readService: no free delay stage for tag %0d", reqData.tag);

endmodule

//--- scoreboard/reorderScoreboard.sv
// Reorder scoreboard: slots are allocated in order, payloads may land in
// any order, and payloads are released strictly in allocation order

`timescale 1ns/100ps

module reorderScoreboard
(
    input  logic                clk,
    input  logic                resetb,

    // Slot allocation, the returned index is where the payload belongs
    input  logic                enqEn,
    output logic                notFull,
    output readEnginePkg::tTag  enqIdx,

    // Payload write, always accepted
    input  logic                enqDataEn,
    input  readEnginePkg::tTag  enqDataIdx,
    input  readEnginePkg::tData enqData,

    // In-order release
    input  logic                deqEn,
    output logic                notEmpty,
    output readEnginePkg::tData first
);

    // Empty when both pointers match, full one slot short of wrapping
    readEnginePkg::tTag newest;
    readEnginePkg::tTag oldest;
    readEnginePkg::tTag oldestNext;

    // Payload arrival flag per slot
    logic [readEnginePkg::sbEntries-1:0] dataValid;
    logic [readEnginePkg::sbEntries-1:0] dataValidNext;

    // Payload storage, read through a register with no write bypass
    readEnginePkg::tData data [readEnginePkg::sbEntries];

    assign notFull = (readEnginePkg::tTag'(newest + 1'b1) != oldest);
    assign enqIdx  = newest;

    // Head moves on the dequeue so the next read already targets the new head
    assign oldestNext = oldest + readEnginePkg::tTag'(deqEn);

    // Allocation pointer
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            newest <= '0;
        end
        else if (enqEn)
        begin
            newest <= newest + 1'b1;
        end
    end

    // Release pointer
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            oldest <= '0;
        end
        else
        begin
            oldest <= oldestNext;
        end
    end

    always_comb
    begin
        dataValidNext = dataValid;

        // Released slot forgets its payload
        if (deqEn)
        begin
            dataValidNext[oldest] = 1'b0;
        end

        // Arriving payload marks its slot
        if (enqDataEn)
        begin
            dataValidNext[enqDataIdx] = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            dataValid <= '0;
        end
        else
        begin
            dataValid <= dataValidNext;
        end
    end

    // Payload memory, the head word is read every cycle
    always_ff @(posedge clk)
    begin
        first <= data[oldestNext];
        if (enqDataEn)
        begin
            data[enqDataIdx] <= enqData;
        end
    end

    // Head flag is taken from the registered bitmap, so it rises exactly
    // when the memory read above can return the written word
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            notEmpty <= 1'b0;
        end
        else
        begin
            notEmpty <= dataValid[oldestNext];
        end
    end

    assert property (@(posedge clk) disable iff (!resetb)
        enqEn |-> notFull)
    else $error("reorderScoreboard: enqueue while full");

    assert property (@(posedge clk) disable iff (!resetb)
        deqEn |-> notEmpty)
    else $error("reorderScoreboard: dequeue while empty");

    // Each slot receives exactly one payload per allocation
    assert property (@(posedge clk) disable iff (!resetb)
        enqDataEn |-> !dataValid[enqDataIdx])
    else $error("reorderScoreboard: second payload for slot %0d", enqDataIdx);

endmodule

//--- sim/readEngineTb.sv
// Testbench for the read engine: preloads the data memory, runs a table of
// read commands and checks every output stream against a model of the memory

`timescale 1ns/100ps

module readEngineTb;

    logic                 clk;
    logic                 resetb;
    logic                 memWrEn;
    readEnginePkg::tAddr  memWrAddr;
    readEnginePkg::tData  memWrData;
    logic                 cmdValid;
    readEnginePkg::tAddr  cmdAddr;
    readEnginePkg::tCount cmdCount;
    logic                 busy;
    logic                 outValid;
    readEnginePkg::tData  outData;
    logic                 cmdDone;

    // Command table, entry r of each queue belongs to row r
    string rowName [$];
    int    rowAddr [$];
    int    rowCount [$];
    bit    rowWhileBusy [$];

    // Same words as written into the DUT memory
    readEnginePkg::tData model [readEnginePkg::memDepth];

    // Output activity seen since the current test started
    readEnginePkg::tData gotWords [$];
    int doneCount;
    int busyCycles;

    int          totalOut;
    int          errorCount;
    int          passCount;
    int          failCount;
    int          cycleCount;
    int          cycleLimit;
    bit          sentWhileBusy;
    logic [15:0] lfsrState;

    readEngine readEngine_i
    (
        .clk       (clk),
        .resetb    (resetb),
        .memWrEn   (memWrEn),
        .memWrAddr (memWrAddr),
        .memWrData (memWrData),
        .cmdValid  (cmdValid),
        .cmdAddr   (cmdAddr),
        .cmdCount  (cmdCount),
        .busy      (busy),
        .outValid  (outValid),
        .outData   (outData),
        .cmdDone   (cmdDone)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois form, taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        logic [15:0] nextState;
        nextState = state >> 1;
        if (state[0])
        begin
            nextState = nextState ^ 16'hB400;
        end
        return nextState;
    endfunction

    // One LFSR step per data bit
    task automatic drawWord(output readEnginePkg::tData word);
        for (int b = 0; b < 32; b++)
        begin
            lfsrState = lfsrStep(lfsrState);
            word[b] = lfsrState[0];
        end
    endtask

    task automatic addRow(input string name, input int addr, input int count, input bit whileBusy);
        rowName.push_back(name);
        rowAddr.push_back(addr);
        rowCount.push_back(count);
        rowWhileBusy.push_back(whileBusy);
    endtask

    task automatic loadTable();
        addRow("singleEven", 10, 1, 1'b0);
        addRow("singleOdd", 11, 1, 1'b0);
        addRow("mixedBurst", 20, 7, 1'b0);
        addRow("wrapBurst", 60, 8, 1'b0);
        // Longest burst a single command can carry
        addRow("fullBurst", 33, 16, 1'b0);
        // Sent while fullBurst is still draining and must be dropped
        addRow("whileBusy", 5, 4, 1'b1);
        addRow("zeroCount", 8, 0, 1'b0);
        addRow("shortWrap", 62, 3, 1'b0);
        addRow("fullWrap", 55, 16, 1'b0);
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("ERR %s expected 0x%08h actual 0x%08h", testName, expected, actual);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string testName, input int errorsBefore);
        if (errorCount == errorsBefore)
        begin
            passCount++;
            $display("PASS %s", testName);
        end
        else
        begin
            failCount++;
            $display("FAIL %s", testName);
        end
    endtask

    task automatic clearObserved();
        gotWords.delete();
        doneCount = 0;
        busyCycles = 0;
    endtask

    // Outputs are all registered, so the falling edge sees them settled
    task automatic stepCycle();
        @(negedge clk);
        if (outValid)
        begin
            gotWords.push_back(outData);
            totalOut++;
        end
        if (cmdDone)
        begin
            doneCount++;
        end
        if (busy)
        begin
            busyCycles++;
        end
    endtask

    task automatic preloadMemory();
        readEnginePkg::tData word;
        for (int a = 0; a < readEnginePkg::memDepth; a++)
        begin
            drawWord(word);
            model[a] = word;
            memWrEn = 1'b1;
            memWrAddr = readEnginePkg::tAddr'(a);
            memWrData = word;
            stepCycle();
        end
        memWrEn = 1'b0;
    endtask

    task automatic runRow(input int r);
        int errorsBefore;
        int waited;
        bit nextIsBusyRow;
        errorsBefore = errorCount;
        clearObserved();
        nextIsBusyRow = (r + 1 < rowName.size()) && rowWhileBusy[r + 1];
        if (rowWhileBusy[r])
        begin
            // The command went out during the previous row, so only stray output matters
            if (!sentWhileBusy)
            begin
                $display("Test %s: engine was never busy, command could not be sent", rowName[r]);
                errorCount++;
            end
            repeat (rowCount[r] + 10)
            begin
                stepCycle();
            end
            checkValue(rowName[r], 0, gotWords.size());
            checkValue(rowName[r], 0, doneCount);
        end
        else
        begin
            cmdValid = 1'b1;
            cmdAddr = readEnginePkg::tAddr'(rowAddr[r]);
            cmdCount = readEnginePkg::tCount'(rowCount[r]);
            stepCycle();
            cmdValid = 1'b0;
            if (rowCount[r] == 0)
            begin
                repeat (10)
                begin
                    stepCycle();
                end
                checkValue(rowName[r], 0, busyCycles);
                checkValue(rowName[r], 0, doneCount);
                checkValue(rowName[r], 0, gotWords.size());
            end
            else
            begin
                waited = 0;
                while (doneCount == 0 && waited < rowCount[r] + 20)
                begin
                    stepCycle();
                    waited++;
                    cmdValid = 1'b0;
                    // Done has to come with the last word
                    if (cmdDone)
                    begin
                        checkValue(rowName[r], 1, outValid);
                    end
                    if (nextIsBusyRow && busy && !sentWhileBusy)
                    begin
                        cmdValid = 1'b1;
                        cmdAddr = readEnginePkg::tAddr'(rowAddr[r + 1]);
                        cmdCount = readEnginePkg::tCount'(rowCount[r + 1]);
                        sentWhileBusy = 1'b1;
                    end
                end
                cmdValid = 1'b0;
                if (doneCount == 0)
                begin
                    $display("Test %s: command did not complete within %0d cycles",
                             rowName[r], waited);
                    errorCount++;
                end
                checkValue(rowName[r], rowCount[r], gotWords.size());
                // Expected words follow the start address and wrap at the top of memory
                for (int i = 0; i < gotWords.size() && i < rowCount[r]; i++)
                begin
                    checkValue(rowName[r], model[(rowAddr[r] + i) % readEnginePkg::memDepth],
                               gotWords[i]);
                end
            end
        end
        reportTest(rowName[r], errorsBefore);
    endtask

    initial
    begin
        int errorsBefore;
        int expectedTotal;
        resetb = 1'b0;
        memWrEn = 1'b0;
        memWrAddr = '0;
        memWrData = '0;
        cmdValid = 1'b0;
        cmdAddr = '0;
        cmdCount = '0;
        totalOut = 0;
        errorCount = 0;
        passCount = 0;
        failCount = 0;
        sentWhileBusy = 1'b0;
        lfsrState = 16'd45;
        loadTable();

        // Room for every row plus its drain, the preload and some slack
        for (int r = 0; r < rowName.size(); r++)
        begin
            cycleLimit += rowCount[r] + 10;
        end
        cycleLimit += readEnginePkg::memDepth + 100;

        repeat (4) @(posedge clk);
        @(negedge clk);
        resetb = 1'b1;

        // Nothing may move while only the memory is being written
        errorsBefore = errorCount;
        clearObserved();
        preloadMemory();
        checkValue("idleAfterReset", 0, busyCycles);
        checkValue("idleAfterReset", 0, gotWords.size());
        checkValue("idleAfterReset", 0, doneCount);
        reportTest("idleAfterReset", errorsBefore);

        for (int r = 0; r < rowName.size(); r++)
        begin
            runRow(r);
        end

        // Only rows taken while idle add words to the stream
        expectedTotal = 0;
        for (int r = 0; r < rowName.size(); r++)
        begin
            if (!rowWhileBusy[r])
            begin
                expectedTotal += rowCount[r];
            end
        end
        errorsBefore = errorCount;
        checkValue("totalWords", expectedTotal, totalOut);
        reportTest("totalWords", errorsBefore);

        $display("Tests: %0d passed, %0d failed, %0d total",
                 passCount, failCount, passCount + failCount);
        if (failCount == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

    // Backstop against a stalled engine
    initial
    begin
        cycleCount = 0;
        wait (cycleLimit > 0);
        while (cycleCount < cycleLimit)
        begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Run timed out after %0d cycles before all tests finished", cycleCount);
        $display("sim failed");
        $finish;
    end

endmodule

//--- sources.f
common/readEnginePkg.sv
verilog/cmdDecode.sv
readService/readService.sv
scoreboard/reorderScoreboard.sv
verilog/resultDrain.sv
verilog/readEngine.sv
sim/readEngineTb.sv

//--- verilog/cmdDecode.sv
// Command splitter: turns a start address and word count into one tagged
// read per word, holding whenever the scoreboard has no free slot

`timescale 1ns/100ps

module cmdDecode
(
    input  logic                   clk,
    input  logic                   resetb,
    input  logic                   cmdValid,
    input  readEnginePkg::tAddr    cmdAddr,
    input  readEnginePkg::tCount   cmdCount,
    input  logic                   busy,
    input  logic                   sbNotFull,
    input  readEnginePkg::tTag     sbEnqIdx,
    output logic                   cmdStart,
    output readEnginePkg::tCount   startCount,
    output logic                   reqValid,
    output readEnginePkg::readReqT reqData
);

    // Address of the next word to request
    readEnginePkg::tAddr nextAddr;

    // Words of the current command not yet requested
    readEnginePkg::tCount remaining;

    // A command is only taken while the engine is idle
    // Zero-length commands are dropped here and never reach the drain stage
    assign cmdStart   = cmdValid && !busy && (cmdCount != '0);
    assign startCount = cmdCount;

    // A request goes out whenever words are left and a slot can be allocated
    // The same strobe allocates the slot, so the tag is the current enqueue index
    assign reqValid     = (remaining != '0) && sbNotFull;
    assign reqData.tag  = sbEnqIdx;
    assign reqData.addr = nextAddr;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            remaining <= '0;
            nextAddr  <= '0;
        end
        else if (cmdStart)
        begin
            // First request goes out on the following cycle
            remaining <= cmdCount;
            nextAddr  <= cmdAddr;
        end
        else if (reqValid)
        begin
            // Address wraps past the top of memory by its own width
            remaining <= remaining - 1'b1;
            nextAddr  <= nextAddr + 1'b1;
        end
    end

    // A stall holds the position in the burst until a slot frees up
    assert property (@(posedge clk) disable iff (!resetb)
        (remaining != '0 && !sbNotFull && !cmdStart) |=>
            ($stable(remaining) && $stable(nextAddr)))
    else $error("cmdDecode: burst position moved during a stall");

endmodule

//--- verilog/readEngine.sv
// Read engine top: command splitter, two-bank memory service and the
// in-order drain stage with its reorder scoreboard

`timescale 1ns/100ps

module readEngine
(
    input  logic                 clk,
    input  logic                 resetb,
    input  logic                 memWrEn,
    input  readEnginePkg::tAddr  memWrAddr,
    input  readEnginePkg::tData  memWrData,
    input  logic                 cmdValid,
    input  readEnginePkg::tAddr  cmdAddr,
    input  readEnginePkg::tCount cmdCount,
    output logic                 busy,
    output logic                 outValid,
    output readEnginePkg::tData  outData,
    output logic                 cmdDone
);

    // Command hand-off to the drain stage
    logic                 cmdStart;
    readEnginePkg::tCount startCount;

    // Tagged requests, which also allocate scoreboard slots
    logic                   reqValid;
    readEnginePkg::readReqT reqData;

    // Scoreboard allocation state seen by the splitter
    logic               sbNotFull;
    readEnginePkg::tTag sbEnqIdx;

    // Out-of-order responses
    logic                   rspValid;
    readEnginePkg::readRspT rspData;

    cmdDecode cmdDecode_i
    (
        .clk        (clk),
        .resetb     (resetb),
        .cmdValid   (cmdValid),
        .cmdAddr    (cmdAddr),
        .cmdCount   (cmdCount),
        .busy       (busy),
        .sbNotFull  (sbNotFull),
        .sbEnqIdx   (sbEnqIdx),
        .cmdStart   (cmdStart),
        .startCount (startCount),
        .reqValid   (reqValid),
        .reqData    (reqData)
    );

    readService readService_i
    (
        .clk       (clk),
        .resetb    (resetb),
        .memWrEn   (memWrEn),
        .memWrAddr (memWrAddr),
        .memWrData (memWrData),
        .reqValid  (reqValid),
        .reqData   (reqData),
        .rspValid  (rspValid),
        .rspData   (rspData)
    );

    resultDrain resultDrain_i
    (
        .clk        (clk),
        .resetb     (resetb),
        .cmdStart   (cmdStart),
        .startCount (startCount),
        .enqEn      (reqValid),
        .sbNotFull  (sbNotFull),
        .sbEnqIdx   (sbEnqIdx),
        .rspValid   (rspValid),
        .rspData    (rspData),
        .busy       (busy),
        .outValid   (outValid),
        .outData    (outData),
        .cmdDone    (cmdDone)
    );

endmodule

//--- verilog/resultDrain.sv
// Drain stage: holds the scoreboard, streams words out in command order
// and flags the last word of each command

`timescale 1ns/100ps

module resultDrain
(
    input  logic                   clk,
    input  logic                   resetb,
    input  logic                   cmdStart,
    input  readEnginePkg::tCount   startCount,
    input  logic                   enqEn,
    output logic                   sbNotFull,
    output readEnginePkg::tTag     sbEnqIdx,
    input  logic                   rspValid,
    input  readEnginePkg::readRspT rspData,
    output logic                   busy,
    output logic                   outValid,
    output readEnginePkg::tData    outData,
    output logic                   cmdDone
);

    readEnginePkg::drainStateT state;

    // Words of the current command still to be sent out
    readEnginePkg::tCount wordsLeft;

    logic                sbNotEmpty;
    readEnginePkg::tData sbFirst;
    logic                deqEn;

    // Responses go straight into their slot by tag
    reorderScoreboard sb_i
    (
        .clk        (clk),
        .resetb     (resetb),
        .enqEn      (enqEn),
        .notFull    (sbNotFull),
        .enqIdx     (sbEnqIdx),
        .enqDataEn  (rspValid),
        .enqDataIdx (rspData.tag),
        .enqData    (rspData.data),
        .deqEn      (deqEn),
        .notEmpty   (sbNotEmpty),
        .first      (sbFirst)
    );

    assign busy  = (state == readEnginePkg::draining);
    assign deqEn = sbNotEmpty && busy;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state     <= readEnginePkg::idle;
            wordsLeft <= '0;
            outValid  <= 1'b0;
            cmdDone   <= 1'b0;
        end
        else
        begin
            outValid <= deqEn;
            cmdDone  <= 1'b0;
            case (state)
                readEnginePkg::idle:
                begin
                    if (cmdStart)
                    begin
                        wordsLeft <= startCount;
                        state     <= readEnginePkg::draining;
                    end
                end
                readEnginePkg::draining:
                begin
                    if (deqEn)
                    begin
                        wordsLeft <= wordsLeft - 1'b1;
                        // Done lines up with the last word on the outputs
                        if (wordsLeft == readEnginePkg::tCount'(1))
                        begin
                            cmdDone <= 1'b1;
                            state   <= readEnginePkg::idle;
                        end
                    end
                end
                default:
                begin
                    state <= readEnginePkg::idle;
                end
            endcase
        end
    end

    // Word register of the output stream
    always_ff @(posedge clk)
    begin
        if (deqEn)
        begin
            outData <= sbFirst;
        end
    end

    // The splitter only starts a command while this stage reports idle
    assert property (@(posedge clk) disable iff (!resetb)
        cmdStart |-> (state == readEnginePkg::idle))
    else $error("resultDrain: command started while draining");

endmodule
